//--- filelist.f
+incdir+verilog
verilog/dcache_pkg.sv
verilog/dcache_req_stage.sv
verilog/dcache_way.sv
verilog/dcache_miss_ctrl.sv
verilog/dcache_top.sv
verif/dcache_asserts.sv
verif/dcache_tb.sv

//--- run.sh
#!/bin/sh
# build and run the dcache testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir "$LOG"

verilator --binary --timing --assert -j 0 --top-module dcache_tb -f filelist.f -o dcache_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

# let assertion errors be counted instead of stopping the run
./obj_dir/dcache_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$LOG"; then
    exit 1
fi
exit 0

//--- verif/dcache_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_tb;

    localparam int NUM_REQ    = 1000;
    localparam int MAX_CYCLES = NUM_REQ * 20;

    logic                  clk;
    logic                  rst;
    logic                  req_valid_i;
    logic                  req_we_i;
    logic [31:0]           req_addr_i;
    logic [3:0]            req_wsel_i;
    logic [31:0]           req_wdata_i;
    logic                  ret_valid_i;
    logic [`DC_LINE_W-1:0] ret_data_i;
    logic                  wr_valid_i;
    wire                   stall_o;
    wire                   data_ok_o;
    wire [31:0]            rdata_o;
    wire                   rd_req_o;
    wire [31:0]            rd_addr_o;
    wire                   wr_req_o;
    wire [31:0]            wr_addr_o;
    wire [`DC_LINE_W-1:0]  wr_data_o;

    logic [31:0]           model_mem [logic [31:0]]; // cpu view by word address
    logic [`DC_LINE_W-1:0] backing   [logic [26:0]]; // memory side by line number
    logic [19:0]           tag_pool  [4];
    logic [6:0]            set_pool  [4];
    bit [19:0]             trk_tag   [`DC_SETS][2];
    bit [1:0]              trk_valid [`DC_SETS];
    bit [1:0]              trk_dirty [`DC_SETS];
    bit                    trk_lru   [`DC_SETS];   // way to evict next

    // access currently in lookup
    logic        lk_valid = 1'b0;
    logic        lk_we    = 1'b0;
    logic [31:0] lk_addr  = '0;
    logic [3:0]  lk_wsel  = '0;
    logic [31:0] lk_wdata = '0;

    logic stall_seen = 1'b0;
    logic saw_rd     = 1'b0;
    logic saw_wr     = 1'b0;
    logic mem_busy   = 1'b0;
    int   wait_cnt   = 0;
    int   errors     = 0;
    int   checks     = 0;
    int   completed  = 0;
    int   cycles     = 0;

    dcache_top u_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wsel_i  (req_wsel_i),
        .req_wdata_i (req_wdata_i),
        .stall_o     (stall_o),
        .data_ok_o   (data_ok_o),
        .rdata_o     (rdata_o),
        .rd_req_o    (rd_req_o),
        .rd_addr_o   (rd_addr_o),
        .ret_valid_i (ret_valid_i),
        .ret_data_i  (ret_data_i),
        .wr_req_o    (wr_req_o),
        .wr_addr_o   (wr_addr_o),
        .wr_data_o   (wr_data_o),
        .wr_valid_i  (wr_valid_i)
    );

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got %h expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // odd multiplier, so every address gets its own word
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_0f0f;
    endfunction

    function automatic logic [31:0] model_word(input logic [31:0] addr);
        return model_mem.exists(addr) ? model_mem[addr] : fill_word(addr);
    endfunction

    function automatic logic [`DC_LINE_W-1:0] mem_line(input logic [31:0] addr);
        logic [`DC_LINE_W-1:0] line;
        if (backing.exists(addr[31:5])) begin
            return backing[addr[31:5]];
        end
        for (int w = 0; w < `DC_WORDS; w++) begin
            line[32*w +: 32] = fill_word({addr[31:5], 3'(w), 2'b00});
        end
        return line;
    endfunction

    // whether the tracker holds the line of this address
    function automatic bit tracked_hit(input logic [31:0] addr);
        logic [6:0] set_idx;
        bit         found;
        set_idx = addr[11:5];
        found   = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (trk_valid[set_idx][i] && trk_tag[set_idx][i] == addr[31:12]) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    task automatic drive_request();
        logic [31:0] addr;
        addr = {tag_pool[2'($urandom())], set_pool[2'($urandom())], 3'($urandom()), 2'b00};
        req_valid_i <= 1'b1;
        req_we_i    <= 1'($urandom());
        req_addr_i  <= addr;
        req_wsel_i  <= 4'($urandom());
        req_wdata_i <= $urandom();
    endtask

    // retire the lookup access against the model and the two-way LRU tracker
    task automatic finish_access();
        logic [6:0]  set_idx;
        logic [19:0] tag;
        logic [31:0] waddr;
        logic [31:0] word;
        logic        hit;
        logic        exp_wb;
        bit          hw;
        bit          v;
        set_idx = lk_addr[11:5];
        tag     = lk_addr[31:12];
        waddr   = {lk_addr[31:2], 2'b00};
        hit     = 1'b0;
        exp_wb  = 1'b0;
        hw      = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (trk_valid[set_idx][i] && trk_tag[set_idx][i] == tag) begin
                hit = 1'b1;
                hw  = 1'(i);
            end
        end
        v = trk_lru[set_idx];
        if (hit) begin
            trk_lru[set_idx]       = !hw;
            trk_dirty[set_idx][hw] = trk_dirty[set_idx][hw] | lk_we;
        end else begin
            exp_wb = trk_valid[set_idx][v] && trk_dirty[set_idx][v];
            trk_tag[set_idx][v]   = tag;
            trk_valid[set_idx][v] = 1'b1;
            trk_dirty[set_idx][v] = lk_we; // write-allocate leaves it dirty
            trk_lru[set_idx]      = !v;
        end
        compare_value("rd_req_o seen", 32'(saw_rd), 32'(!hit));
        compare_value("wr_req_o seen", 32'(saw_wr), 32'(exp_wb));
        word = model_word(waddr);
        if (lk_we) begin
            for (int b = 0; b < 4; b++) begin
                if (lk_wsel[b]) word[8*b +: 8] = lk_wdata[8*b +: 8];
            end
            model_mem[waddr] = word;
        end else begin
            compare_value("rdata_o", rdata_o, word);
        end
        saw_rd = 1'b0;
        saw_wr = 1'b0;
        completed++;
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: only %0d of %0d requests finished", completed, NUM_REQ);
            $display("Done: errors found");
            $finish;
        end
    end

    // memory answers after 1 to 4 cycles
    always @(posedge clk) begin
        ret_valid_i <= 1'b0;
        wr_valid_i  <= 1'b0;
        if (rst && !ret_valid_i && !wr_valid_i && (rd_req_o || wr_req_o)) begin
            if (!mem_busy) begin
                mem_busy <= 1'b1;
                wait_cnt <= $urandom_range(4, 1);
            end else if (wait_cnt > 1) begin
                wait_cnt <= wait_cnt - 1;
            end else begin
                mem_busy <= 1'b0;
                if (rd_req_o) begin
                    ret_valid_i <= 1'b1;
                    ret_data_i  <= mem_line(rd_addr_o);
                end else begin
                    wr_valid_i <= 1'b1;
                end
            end
        end
    end

    // outputs are settled at the falling edge
    always @(negedge clk) begin : monitor
        logic [6:0] set_idx;
        bit         v;
        bit         exp_stall;
        stall_seen = stall_o;
        set_idx    = lk_addr[11:5];
        v          = trk_lru[set_idx];
        if (!rst) begin
            lk_valid = 1'b0;
        end else begin
            if (rd_req_o) begin
                saw_rd = 1'b1;
                compare_value("rd_addr_o", rd_addr_o, {lk_addr[31:5], 5'b0});
            end
            if (wr_req_o) begin
                saw_wr = 1'b1;
                compare_value("wr_addr_o", wr_addr_o, {trk_tag[set_idx][v], set_idx, 5'b0});
            end
            if (wr_req_o && wr_valid_i) begin
                for (int w = 0; w < `DC_WORDS; w++) begin
                    compare_value("wr_data_o", wr_data_o[32*w +: 32],
                                  model_word(wr_addr_o + 32'(4 * w)));
                end
                backing[wr_addr_o[31:5]] = wr_data_o;
            end
            // a miss stalls until its line comes back
            exp_stall = lk_valid && !tracked_hit(lk_addr) && !ret_valid_i;
            compare_value("stall_o", 32'(stall_o), 32'(exp_stall));
            compare_value("data_ok_o", 32'(data_ok_o), 32'(!exp_stall && lk_valid && !lk_we));
            if (!stall_o) begin
                if (lk_valid) begin
                    finish_access();
                end
                lk_valid = req_valid_i; // taken at the coming edge
                lk_we    = req_we_i;
                lk_addr  = req_addr_i;
                lk_wsel  = req_wsel_i;
                lk_wdata = req_wdata_i;
            end
        end
    end

    initial begin : stimulus
        int sent;
        int total;
        void'($urandom(32'h3789));
        rst         = 1'b0;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_wsel_i  = '0;
        req_wdata_i = '0;
        ret_valid_i = 1'b0;
        ret_data_i  = '0;
        wr_valid_i  = 1'b0;
        for (int i = 0; i < 4; i++) begin
            tag_pool[i] = {18'($urandom()), 2'(i)}; // low bits keep them apart
            set_pool[i] = {5'($urandom()), 2'(i)};
        end
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        sent = 0;
        while (sent < NUM_REQ) begin
            @(posedge clk);
            if (!stall_seen) begin
                if ($urandom_range(3) == 0) begin
                    req_valid_i <= 1'b0; // idle gap
                end else begin
                    drive_request();
                    sent++;
                end
            end
        end
        @(posedge clk);
        while (stall_seen) @(posedge clk);
        req_valid_i <= 1'b0;
        wait (completed == NUM_REQ);
        @(posedge clk);
        total = errors + int'(u_dcache_top.u_asserts.fail_count);
        $display("requests: %0d, checks: %0d, errors: %0d", completed, checks, total);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/dcache_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_asserts (
    input wire clk,
    input wire rst,
    input wire stall_o,
    input wire data_ok_o,
    input wire rd_req_o,
    input wire wr_req_o,
    input wire ret_valid_i
);

    int unsigned fail_count = 0;

    a_reset_quiet: assert property (@(posedge clk)
        $rose(rst) |-> !stall_o && !rd_req_o && !wr_req_o)
        else begin
            fail_count++;
            $error("stall or memory request active right after reset");
        end

    // write-back and refill are serialized
    a_one_mem_req: assert property (@(posedge clk) disable iff (!rst)
        !(rd_req_o && wr_req_o))
        else begin
            fail_count++;
            $error("read and write requests high together");
        end

    a_rd_held: assert property (@(posedge clk) disable iff (!rst)
        rd_req_o && !ret_valid_i |=> rd_req_o)
        else begin
            fail_count++;
            $error("read request dropped before the line returned");
        end

    a_ok_not_stalled: assert property (@(posedge clk) disable iff (!rst)
        data_ok_o |-> !stall_o)
        else begin
            fail_count++;
            $error("data_ok_o high while stalled");
        end

endmodule

bind dcache_top dcache_asserts u_asserts (
    .clk         (clk),
    .rst         (rst),
    .stall_o     (stall_o),
    .data_ok_o   (data_ok_o),
    .rd_req_o    (rd_req_o),
    .wr_req_o    (wr_req_o),
    .ret_valid_i (ret_valid_i)
);

`default_nettype wire

//--- verilog/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_top (
    input  wire                          clk,
    input  wire                          rst,
    // cpu
    input  wire                          req_valid_i,
    input  wire                          req_we_i,
    input  wire [`DC_ADDR_W-1:0]         req_addr_i,
    input  wire [3:0]                    req_wsel_i,
    input  wire dcache_pkg::word_t       req_wdata_i,
    output wire                          stall_o,
    output wire                          data_ok_o,
    output wire dcache_pkg::word_t       rdata_o,
    // memory
    output wire                          rd_req_o,
    output wire [`DC_ADDR_W-1:0]         rd_addr_o,
    input  wire                          ret_valid_i,
    input  wire [`DC_LINE_W-1:0]         ret_data_i,
    output wire                          wr_req_o,
    output wire [`DC_ADDR_W-1:0]         wr_addr_o,
    output wire [`DC_LINE_W-1:0]         wr_data_o,
    input  wire                          wr_valid_i
);
    import dcache_pkg::*;

    // lookup stage
    wire mem_op_e          lk_op;
    wire tag_t             lk_tag;
    wire index_t           lk_index;
    wire word_sel_t        lk_word_sel;
    wire [3:0]             lk_wsel;
    wire word_t            lk_wdata;

    // way read and write buses
    wire [`DC_WAYS-1:0]    way_hit;
    wire [`DC_WAYS-1:0]    way_dirty;
    wire [`DC_WAYS-1:0]    way_we;
    wire line_t            way_line       [`DC_WAYS];
    wire tag_t             way_victim_tag [`DC_WAYS];
    wire line_t            fill_line;
    wire                   fill_dirty;

    dcache_req_stage u_req_stage (
        .clk         (clk),
        .rst         (rst),
        .stall_i     (stall_o),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wsel_i  (req_wsel_i),
        .req_wdata_i (req_wdata_i),
        .op_o        (lk_op),
        .tag_o       (lk_tag),
        .index_o     (lk_index),
        .word_sel_o  (lk_word_sel),
        .wsel_o      (lk_wsel),
        .wdata_o     (lk_wdata)
    );

    for (genvar i = 0; i < `DC_WAYS; i++) begin : g_way
        dcache_way u_way (
            .clk          (clk),
            .rst          (rst),
            .index_i      (lk_index),
            .tag_i        (lk_tag),
            .we_i         (way_we[i]),
            .line_i       (fill_line),
            .dirty_i      (fill_dirty),
            .hit_o        (way_hit[i]),
            .line_o       (way_line[i]),
            .victim_tag_o (way_victim_tag[i]),
            .dirty_o      (way_dirty[i])
        );
    end

    dcache_miss_ctrl u_miss_ctrl (
        .clk          (clk),
        .rst          (rst),
        .op_i         (lk_op),
        .tag_i        (lk_tag),
        .index_i      (lk_index),
        .word_sel_i   (lk_word_sel),
        .wsel_i       (lk_wsel),
        .wdata_i      (lk_wdata),
        .hit_i        (way_hit),
        .line_i       (way_line),
        .victim_tag_i (way_victim_tag),
        .dirty_i      (way_dirty),
        .ret_valid_i  (ret_valid_i),
        .ret_data_i   (ret_data_i),
        .wr_valid_i   (wr_valid_i),
        .way_we_o     (way_we),
        .way_line_o   (fill_line),
        .way_dirty_o  (fill_dirty),
        .stall_o      (stall_o),
        .data_ok_o    (data_ok_o),
        .rdata_o      (rdata_o),
        .rd_req_o     (rd_req_o),
        .rd_addr_o    (rd_addr_o),
        .wr_req_o     (wr_req_o),
        .wr_addr_o    (wr_addr_o),
        .wr_data_o    (wr_data_o)
    );

endmodule

`default_nettype wire

//--- verilog/dcache_miss_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_miss_ctrl (
    input  wire                          clk,
    input  wire                          rst,
    input  wire dcache_pkg::mem_op_e     op_i,
    input  wire dcache_pkg::tag_t        tag_i,
    input  wire dcache_pkg::index_t      index_i,
    input  wire dcache_pkg::word_sel_t   word_sel_i,
    input  wire [3:0]                    wsel_i,
    input  wire dcache_pkg::word_t       wdata_i,
    input  wire [`DC_WAYS-1:0]           hit_i,
    input  wire dcache_pkg::line_t       line_i       [`DC_WAYS],
    input  wire dcache_pkg::tag_t        victim_tag_i [`DC_WAYS],
    input  wire [`DC_WAYS-1:0]           dirty_i,
    input  wire                          ret_valid_i,
    input  wire dcache_pkg::line_t       ret_data_i,
    input  wire                          wr_valid_i,
    output logic [`DC_WAYS-1:0]          way_we_o,
    output dcache_pkg::line_t            way_line_o,
    output logic                         way_dirty_o,
    output logic                         stall_o,
    output logic                         data_ok_o,
    output dcache_pkg::word_t            rdata_o,
    output logic                         rd_req_o,
    output logic [`DC_ADDR_W-1:0]        rd_addr_o,
    output logic                         wr_req_o,
    output logic [`DC_ADDR_W-1:0]        wr_addr_o,
    output dcache_pkg::line_t            wr_data_o
);
    import dcache_pkg::*;

    miss_state_e         state_q;
    miss_state_e         state_d;
    logic [`DC_SETS-1:0] lru_q;      // set bit names the way to evict
    logic                hit_way;
    logic                victim_way;
    logic                lookup_hit;
    logic                miss;
    logic                fill;
    word_t               wmask;
    line_t               base_line;
    line_t               merged_line;

    assign hit_way    = hit_i[1];
    assign victim_way = lru_q[index_i];
    assign lookup_hit = (state_q == st_lookup) && (op_i != op_none) && (|hit_i);
    assign miss       = (state_q == st_lookup) && (op_i != op_none) && !(|hit_i);
    assign fill       = (state_q == st_refill) && ret_valid_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_lookup: begin
                if (miss) begin
                    state_d = dirty_i[victim_way] ? st_writeback : st_refill;
                end
            end
            st_writeback: begin
                if (wr_valid_i) begin
                    state_d = st_refill;
                end
            end
            st_refill: begin
                if (ret_valid_i) begin
                    state_d = st_lookup;
                end
            end
            default: state_d = st_lookup;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q <= st_lookup;
            lru_q   <= '0;
        end else begin
            state_q <= state_d;
            if (lookup_hit) begin
                lru_q[index_i] <= ~hit_way;
            end else if (fill) begin
                lru_q[index_i] <= ~victim_way;
            end
        end
    end

    // byte mask to bit mask
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            wmask[8*b +: 8] = {8{wsel_i[b]}};
        end
    end

    // store data goes over the hit line or the line coming back from memory
    assign base_line = (state_q == st_refill) ? ret_data_i : line_i[hit_way];

    always_comb begin
        merged_line = base_line;
        merged_line[word_sel_i] = (wdata_i & wmask) | (base_line[word_sel_i] & ~wmask);
    end

    always_comb begin
        way_we_o = '0;
        if (lookup_hit && op_i == op_write) begin
            way_we_o[hit_way] = 1'b1;
        end
        if (fill) begin
            way_we_o[victim_way] = 1'b1;
        end
    end

    assign way_line_o  = (op_i == op_write) ? merged_line : base_line;
    assign way_dirty_o = (op_i == op_write); // clean after a read fill

    // cpu side
    assign stall_o   = miss || (state_q == st_writeback) || (state_q == st_refill && !ret_valid_i);
    assign data_ok_o = (op_i == op_read) && (lookup_hit || fill);
    assign rdata_o   = base_line[word_sel_i];

    // write-back finishes before the refill starts
    assign wr_req_o  = (state_q == st_writeback);
    assign wr_addr_o = {victim_tag_i[victim_way], index_i, {`DC_OFFSET_W{1'b0}}};
    assign wr_data_o = line_i[victim_way];
    assign rd_req_o  = (state_q == st_refill);
    assign rd_addr_o = {tag_i, index_i, {`DC_OFFSET_W{1'b0}}};

endmodule

`default_nettype wire

//--- verilog/dcache_way.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_way (
    input  wire                          clk,
    input  wire                          rst,
    input  wire dcache_pkg::index_t      index_i,
    input  wire dcache_pkg::tag_t        tag_i,
    input  wire                          we_i,
    input  wire dcache_pkg::line_t       line_i,
    input  wire                          dirty_i,
    output logic                         hit_o,
    output dcache_pkg::line_t            line_o,
    output dcache_pkg::tag_t             victim_tag_o,
    output logic                         dirty_o
);
    import dcache_pkg::*;

    logic [`DC_SETS-1:0] valid_q;
    logic [`DC_SETS-1:0] dirty_q;
    tag_t                tag_q  [`DC_SETS];
    line_t               line_q [`DC_SETS];

    // status bits
    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (we_i) begin
            valid_q[index_i] <= 1'b1;
            dirty_q[index_i] <= dirty_i;
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[index_i]  <= tag_i;
            line_q[index_i] <= line_i;
        end
    end

    // read side is combinational, a write shows up on the next access
    assign hit_o        = valid_q[index_i] && (tag_q[index_i] == tag_i);
    assign line_o       = line_q[index_i];
    assign victim_tag_o = tag_q[index_i];
    assign dirty_o      = dirty_q[index_i]; // only ever set together with valid

endmodule

`default_nettype wire

//--- verilog/dcache_req_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_macros.svh"

module dcache_req_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          stall_i,
    input  wire                          req_valid_i,
    input  wire                          req_we_i,
    input  wire [`DC_ADDR_W-1:0]         req_addr_i,
    input  wire [3:0]                    req_wsel_i,
    input  wire dcache_pkg::word_t       req_wdata_i,
    output dcache_pkg::mem_op_e          op_o,
    output dcache_pkg::tag_t             tag_o,
    output dcache_pkg::index_t           index_o,
    output dcache_pkg::word_sel_t        word_sel_o,
    output logic [3:0]                   wsel_o,
    output dcache_pkg::word_t            wdata_o
);
    import dcache_pkg::*;

    mem_op_e op_d;

    // valid and write enable folded into one opcode
    assign op_d = req_valid_i ? (req_we_i ? op_write : op_read) : op_none;

    always_ff @(posedge clk) begin
        if (!rst) begin
            op_o <= op_none;
        end else if (!stall_i) begin
            op_o <= op_d;
        end
    end

    // payload held during a miss
    always_ff @(posedge clk) begin
        if (!stall_i) begin
            tag_o      <= req_addr_i[`DC_ADDR_W-1 -: `DC_TAG_W];
            index_o    <= req_addr_i[`DC_OFFSET_W +: `DC_INDEX_W];
            word_sel_o <= req_addr_i[`DC_OFFSET_W-1:2]; // drop byte bits
            wsel_o     <= req_wsel_i;
            wdata_o    <= req_wdata_i;
        end
    end

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
`default_nettype none

`include "dcache_macros.svh"

package dcache_pkg;

    typedef logic [`DC_TAG_W-1:0]          tag_t;
    typedef logic [`DC_INDEX_W-1:0]        index_t;
    typedef logic [$clog2(`DC_WORDS)-1:0]  word_sel_t;
    typedef logic [`DC_WORD_W-1:0]         word_t;
    typedef logic [`DC_WORDS-1:0][`DC_WORD_W-1:0] line_t; // word 0 in the low bits

    typedef enum logic [1:0] {
        op_none  = 2'd0,
        op_read  = 2'd1,
        op_write = 2'd2
    } mem_op_e;

    typedef enum logic [1:0] {
        st_lookup    = 2'd0,
        st_writeback = 2'd1,
        st_refill    = 2'd2
    } miss_state_e;

endpackage

`default_nettype wire

//--- verilog/dcache_macros.svh
`ifndef DCACHE_MACROS_SVH
`define DCACHE_MACROS_SVH

// address split into tag, index and byte offset
`define DC_ADDR_W   32
`define DC_TAG_W    20
`define DC_INDEX_W  7
`define DC_OFFSET_W 5

// data widths
`define DC_WORD_W   32
`define DC_WORDS    8
`define DC_LINE_W   256

// geometry
`define DC_SETS     128
`define DC_WAYS     2 // LRU logic assumes two ways

`endif
